// File: verilog.f
+incdir+include
hw/axis5_pkg.sv
hw/axis5_skid_buffer.sv
hw/axis5_parity_checker.sv
hw/axis5_master.sv
testbench/axis5_master_tb.sv

// File: Makefile
# Verilator build and run for the AXI5-Stream master stage

TOP := axis5_master_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: include/axis5_tb_vectors.svh
// axis5_tb_vectors: stimulus beats for the AXI5-Stream master testbench

`ifndef AXIS5_TB_VECTORS_SVH
`define AXIS5_TB_VECTORS_SVH

// Each output beat is expected to carry its row unchanged
localparam int NUM_VECTORS = 12;
localparam int VEC_STRB_WIDTH = axis5_pkg::DEFAULT_DATA_WIDTH / axis5_pkg::BYTE_WIDTH;

localparam logic [axis5_pkg::DEFAULT_DATA_WIDTH-1:0] VEC_TDATA [NUM_VECTORS] = '{
    32'h0000_0001, 32'hdead_beef, 32'h1234_5678, 32'hffff_ffff,
    32'h0f0f_f0f0, 32'ha5a5_5a5a, 32'h8000_0000, 32'h7654_3210,
    32'hcafe_f00d, 32'h0102_0408, 32'h1357_9bdf, 32'h0000_0000
};

localparam logic [VEC_STRB_WIDTH-1:0] VEC_TSTRB [NUM_VECTORS] = '{
    4'hf, 4'hf, 4'h3, 4'hf, 4'hc, 4'hf,
    4'h1, 4'hf, 4'hf, 4'h8, 4'hf, 4'h0
};

localparam logic VEC_TLAST [NUM_VECTORS] = '{
    1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1,
    1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1
};

localparam logic [axis5_pkg::DEFAULT_ID_WIDTH-1:0] VEC_TID [NUM_VECTORS] = '{
    8'h01, 8'h01, 8'h01, 8'h22, 8'h22, 8'h22,
    8'h3c, 8'h4d, 8'h4d, 8'h4d, 8'h4d, 8'hff
};

localparam logic [axis5_pkg::DEFAULT_DEST_WIDTH-1:0] VEC_TDEST [NUM_VECTORS] = '{
    4'h0, 4'h0, 4'h0, 4'h5, 4'h5, 4'h5,
    4'ha, 4'h3, 4'h3, 4'h3, 4'h3, 4'hf
};

localparam logic [axis5_pkg::DEFAULT_USER_WIDTH-1:0] VEC_TUSER [NUM_VECTORS] = '{
    1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
    1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1
};

localparam logic VEC_TWAKEUP [NUM_VECTORS] = '{
    1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0,
    1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0
};

// Rows whose driven tparity gets one bit inverted
localparam logic VEC_CORRUPT [NUM_VECTORS] = '{
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
    1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0
};

`endif

// File: testbench/axis5_master_tb.sv
// axis5_master_tb: table-driven testbench for the AXI5-Stream master output stage

`timescale 1ns/1ps

module axis5_master_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    localparam int SKID_DEPTH = axis5_pkg::DEFAULT_SKID_DEPTH;
    localparam int DATA_W = axis5_pkg::DEFAULT_DATA_WIDTH;
    localparam int ID_W = axis5_pkg::DEFAULT_ID_WIDTH;
    localparam int DEST_W = axis5_pkg::DEFAULT_DEST_WIDTH;
    localparam int USER_W = axis5_pkg::DEFAULT_USER_WIDTH;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int HOLD_CYCLES = 3;

    `include "axis5_tb_vectors.svh"

    logic                      aclk;
    logic                      aresetn;
    logic [DATA_W-1:0]         fub_axis_tdata;
    logic [VEC_STRB_WIDTH-1:0] fub_axis_tstrb;
    logic                      fub_axis_tlast;
    logic [ID_W-1:0]           fub_axis_tid;
    logic [DEST_W-1:0]         fub_axis_tdest;
    logic [USER_W-1:0]         fub_axis_tuser;
    logic                      fub_axis_twakeup;
    logic [VEC_STRB_WIDTH-1:0] fub_axis_tparity;
    logic                      fub_axis_tvalid;
    logic                      fub_axis_tready;
    logic [DATA_W-1:0]         m_axis_tdata;
    logic [VEC_STRB_WIDTH-1:0] m_axis_tstrb;
    logic                      m_axis_tlast;
    logic [ID_W-1:0]           m_axis_tid;
    logic [DEST_W-1:0]         m_axis_tdest;
    logic [USER_W-1:0]         m_axis_tuser;
    logic                      m_axis_twakeup;
    logic [VEC_STRB_WIDTH-1:0] m_axis_tparity;
    logic                      m_axis_tvalid;
    logic                      m_axis_tready;
    logic                      busy;
    logic                      parity_error;

    integer seed = 68966;
    logic   stall_sink = 1'b1;
    int     error_count = 0;
    int     timeout_count = 0;
    int     received_count = 0;
    logic   corrupt_seen = 1'b0;

    axis5_master #(
        .SKID_DEPTH      (SKID_DEPTH),
        .AXIS_DATA_WIDTH (DATA_W),
        .AXIS_ID_WIDTH   (ID_W),
        .AXIS_DEST_WIDTH (DEST_W),
        .AXIS_USER_WIDTH (USER_W),
        .ENABLE_WAKEUP   (1'b1),
        .ENABLE_PARITY   (1'b1)
    ) axis5_master_inst (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .fub_axis_tdata   (fub_axis_tdata),
        .fub_axis_tstrb   (fub_axis_tstrb),
        .fub_axis_tlast   (fub_axis_tlast),
        .fub_axis_tid     (fub_axis_tid),
        .fub_axis_tdest   (fub_axis_tdest),
        .fub_axis_tuser   (fub_axis_tuser),
        .fub_axis_twakeup (fub_axis_twakeup),
        .fub_axis_tparity (fub_axis_tparity),
        .fub_axis_tvalid  (fub_axis_tvalid),
        .fub_axis_tready  (fub_axis_tready),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_tstrb     (m_axis_tstrb),
        .m_axis_tlast     (m_axis_tlast),
        .m_axis_tid       (m_axis_tid),
        .m_axis_tdest     (m_axis_tdest),
        .m_axis_tuser     (m_axis_tuser),
        .m_axis_twakeup   (m_axis_twakeup),
        .m_axis_tparity   (m_axis_tparity),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tready    (m_axis_tready),
        .busy             (busy),
        .parity_error     (parity_error)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Sink ready turns random once the back-pressure phase is over
    initial begin
        logic [31:0] rand_word;
        m_axis_tready = 1'b0;
        forever begin
            @(negedge aclk);
            if (stall_sink) begin
                m_axis_tready = 1'b0;
            end else begin
                rand_word = $random(seed);
                m_axis_tready = rand_word[0];
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // XOR of each byte lane, bit by bit
    function automatic logic [VEC_STRB_WIDTH-1:0] lane_parity(input logic [DATA_W-1:0] data);
        logic [VEC_STRB_WIDTH-1:0] par;
        par = '0;
        for (int bit_idx = 0; bit_idx < DATA_W; bit_idx++) begin
            par[bit_idx / axis5_pkg::BYTE_WIDTH] ^= data[bit_idx];
        end
        return par;
    endfunction

    // Corrupt rows get lane 0 inverted
    function automatic logic [VEC_STRB_WIDTH-1:0] row_parity(input int row);
        return lane_parity(VEC_TDATA[row]) ^ VEC_STRB_WIDTH'(VEC_CORRUPT[row]);
    endfunction

    task automatic apply_row(input int row);
        fub_axis_tdata = VEC_TDATA[row];
        fub_axis_tstrb = VEC_TSTRB[row];
        fub_axis_tlast = VEC_TLAST[row];
        fub_axis_tid = VEC_TID[row];
        fub_axis_tdest = VEC_TDEST[row];
        fub_axis_tuser = VEC_TUSER[row];
        fub_axis_twakeup = VEC_TWAKEUP[row];
        fub_axis_tparity = row_parity(row);
        fub_axis_tvalid = 1'b1;
    endtask

    task automatic drive_rows();
        int   cycles;
        logic accepted;
        for (int row = 0; row < NUM_VECTORS; row++) begin
            @(negedge aclk);
            apply_row(row);
            // Sink stalled so far so the buffer must be full now
            if (row == SKID_DEPTH) begin
                check_value("fub_axis_tready", 1'b0, fub_axis_tready);
                check_value("m_axis_tvalid", 1'b1, m_axis_tvalid);
                repeat (HOLD_CYCLES) begin
                    @(posedge aclk);
                    check_value("fub_axis_tready", 1'b0, fub_axis_tready);
                end
                stall_sink = 1'b0;
            end
            cycles = 0;
            accepted = 1'b0;
            while (!accepted && cycles < ACCEPT_TIMEOUT) begin
                @(posedge aclk);
                cycles++;
                check_value("busy", 1'b1, busy);
                accepted = fub_axis_tready;
            end
            if (!accepted) begin
                $display("TIMEOUT at %0t ns: row %0d was not accepted within %0d cycles",
                         $time, row, ACCEPT_TIMEOUT);
                timeout_count++;
                return;
            end
        end
        @(negedge aclk);
        fub_axis_tvalid = 1'b0;
    endtask

    task automatic compare_beat(input int row);
        check_value("m_axis_tdata", VEC_TDATA[row], m_axis_tdata);
        check_value("m_axis_tstrb", VEC_TSTRB[row], m_axis_tstrb);
        check_value("m_axis_tlast", VEC_TLAST[row], m_axis_tlast);
        check_value("m_axis_tid", VEC_TID[row], m_axis_tid);
        check_value("m_axis_tdest", VEC_TDEST[row], m_axis_tdest);
        check_value("m_axis_tuser", VEC_TUSER[row], m_axis_tuser);
        check_value("m_axis_twakeup", VEC_TWAKEUP[row], m_axis_twakeup);
        check_value("m_axis_tparity", row_parity(row), m_axis_tparity);
    endtask

    // Pre-edge values at each rising edge, so the flag reflects earlier transfers only
    task automatic collect_beats();
        int cycles;
        cycles = 0;
        while (received_count < NUM_VECTORS && cycles < DRAIN_TIMEOUT) begin
            @(posedge aclk);
            cycles++;
            check_value("parity_error", corrupt_seen, parity_error);
            // A stored beat keeps busy high even with nothing offered
            if (m_axis_tvalid) begin
                check_value("busy", 1'b1, busy);
            end
            if (m_axis_tvalid && m_axis_tready) begin
                compare_beat(received_count);
                corrupt_seen = corrupt_seen | VEC_CORRUPT[received_count];
                received_count++;
            end
        end
        if (received_count < NUM_VECTORS) begin
            $display("TIMEOUT at %0t ns: only %0d of %0d beats left on the m side",
                     $time, received_count, NUM_VECTORS);
            timeout_count++;
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d of %0d beats received, %0d check errors, %0d timeouts",
                 received_count, NUM_VECTORS, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin
        aresetn = 1'b0;
        fub_axis_tdata = '0;
        fub_axis_tstrb = '0;
        fub_axis_tlast = 1'b0;
        fub_axis_tid = '0;
        fub_axis_tdest = '0;
        fub_axis_tuser = '0;
        fub_axis_twakeup = 1'b0;
        fub_axis_tparity = '0;
        fub_axis_tvalid = 1'b0;

        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // Idle state out of reset
        @(negedge aclk);
        check_value("m_axis_tvalid", 1'b0, m_axis_tvalid);
        check_value("busy", 1'b0, busy);
        check_value("parity_error", 1'b0, parity_error);
        check_value("fub_axis_tready", 1'b1, fub_axis_tready);

        fork
            drive_rows();
            collect_beats();
        join

        // Drained and idle with the sticky flag held
        @(negedge aclk);
        check_value("m_axis_tvalid", 1'b0, m_axis_tvalid);
        check_value("busy", 1'b0, busy);
        check_value("fub_axis_tready", 1'b1, fub_axis_tready);
        check_value("parity_error", corrupt_seen, parity_error);

        finish_run();
    end

endmodule : axis5_master_tb

// File: hw/axis5_master.sv
// axis5_master: AXI5-Stream master output stage with skid FIFO and tparity checking

`timescale 1ns/1ps

module axis5_master #(
    parameter int SKID_DEPTH = axis5_pkg::DEFAULT_SKID_DEPTH,
    parameter int AXIS_DATA_WIDTH = axis5_pkg::DEFAULT_DATA_WIDTH,
    parameter int AXIS_ID_WIDTH = axis5_pkg::DEFAULT_ID_WIDTH,
    parameter int AXIS_DEST_WIDTH = axis5_pkg::DEFAULT_DEST_WIDTH,
    parameter int AXIS_USER_WIDTH = axis5_pkg::DEFAULT_USER_WIDTH,
    parameter bit ENABLE_WAKEUP = 1'b1,
    parameter bit ENABLE_PARITY = 1'b1,
    localparam int STRB_WIDTH = AXIS_DATA_WIDTH / axis5_pkg::BYTE_WIDTH,
    // Absent fields keep a one-bit port driven as zero
    localparam int ID_PORT_WIDTH = (AXIS_ID_WIDTH > 0) ? AXIS_ID_WIDTH : 1,
    localparam int DEST_PORT_WIDTH = (AXIS_DEST_WIDTH > 0) ? AXIS_DEST_WIDTH : 1,
    localparam int USER_PORT_WIDTH = (AXIS_USER_WIDTH > 0) ? AXIS_USER_WIDTH : 1,
    localparam int PARITY_PORT_WIDTH = ENABLE_PARITY ? STRB_WIDTH : 1
) (
    input  logic                         aclk,
    input  logic                         aresetn,

    // fub side
    input  logic [AXIS_DATA_WIDTH-1:0]   fub_axis_tdata,
    input  logic [STRB_WIDTH-1:0]        fub_axis_tstrb,
    input  logic                         fub_axis_tlast,
    input  logic [ID_PORT_WIDTH-1:0]     fub_axis_tid,
    input  logic [DEST_PORT_WIDTH-1:0]   fub_axis_tdest,
    input  logic [USER_PORT_WIDTH-1:0]   fub_axis_tuser,
    input  logic                         fub_axis_twakeup,
    input  logic [PARITY_PORT_WIDTH-1:0] fub_axis_tparity,
    input  logic                         fub_axis_tvalid,
    output logic                         fub_axis_tready,

    // Master side
    output logic [AXIS_DATA_WIDTH-1:0]   m_axis_tdata,
    output logic [STRB_WIDTH-1:0]        m_axis_tstrb,
    output logic                         m_axis_tlast,
    output logic [ID_PORT_WIDTH-1:0]     m_axis_tid,
    output logic [DEST_PORT_WIDTH-1:0]   m_axis_tdest,
    output logic [USER_PORT_WIDTH-1:0]   m_axis_tuser,
    output logic                         m_axis_twakeup,
    output logic [PARITY_PORT_WIDTH-1:0] m_axis_tparity,
    output logic                         m_axis_tvalid,
    input  logic                         m_axis_tready,

    // Status
    output logic                         busy,
    output logic                         parity_error
);

    // Beat word layout, LSB first: tparity, twakeup, tuser, tdest, tid, tlast, tstrb, tdata
    localparam int PAR_BITS = ENABLE_PARITY ? STRB_WIDTH : 0;
    localparam int WAKE_BITS = ENABLE_WAKEUP ? 1 : 0;
    localparam int WAKE_LSB = PAR_BITS;
    localparam int USER_LSB = WAKE_LSB + WAKE_BITS;
    localparam int DEST_LSB = USER_LSB + AXIS_USER_WIDTH;
    localparam int ID_LSB = DEST_LSB + AXIS_DEST_WIDTH;
    localparam int LAST_LSB = ID_LSB + AXIS_ID_WIDTH;
    localparam int STRB_LSB = LAST_LSB + 1;
    localparam int DATA_LSB = STRB_LSB + STRB_WIDTH;
    localparam int BEAT_WIDTH = DATA_LSB + AXIS_DATA_WIDTH;
    localparam int COUNT_WIDTH = $clog2(SKID_DEPTH + 1);

    logic [BEAT_WIDTH-1:0]  beat_in;
    logic [BEAT_WIDTH-1:0]  beat_out;
    logic [COUNT_WIDTH-1:0] buf_count;

    // Core fields always travel
    assign beat_in[DATA_LSB +: AXIS_DATA_WIDTH] = fub_axis_tdata;
    assign beat_in[STRB_LSB +: STRB_WIDTH] = fub_axis_tstrb;
    assign beat_in[LAST_LSB] = fub_axis_tlast;

    assign m_axis_tdata = beat_out[DATA_LSB +: AXIS_DATA_WIDTH];
    assign m_axis_tstrb = beat_out[STRB_LSB +: STRB_WIDTH];
    assign m_axis_tlast = beat_out[LAST_LSB];

    // Optional fields take storage only when present
    if (AXIS_ID_WIDTH > 0) begin : g_tid
        assign beat_in[ID_LSB +: AXIS_ID_WIDTH] = fub_axis_tid;
        assign m_axis_tid = beat_out[ID_LSB +: AXIS_ID_WIDTH];
    end else begin : g_no_tid
        assign m_axis_tid = '0;
    end

    if (AXIS_DEST_WIDTH > 0) begin : g_tdest
        assign beat_in[DEST_LSB +: AXIS_DEST_WIDTH] = fub_axis_tdest;
        assign m_axis_tdest = beat_out[DEST_LSB +: AXIS_DEST_WIDTH];
    end else begin : g_no_tdest
        assign m_axis_tdest = '0;
    end

    if (AXIS_USER_WIDTH > 0) begin : g_tuser
        assign beat_in[USER_LSB +: AXIS_USER_WIDTH] = fub_axis_tuser;
        assign m_axis_tuser = beat_out[USER_LSB +: AXIS_USER_WIDTH];
    end else begin : g_no_tuser
        assign m_axis_tuser = '0;
    end

    if (ENABLE_WAKEUP) begin : g_twakeup
        assign beat_in[WAKE_LSB] = fub_axis_twakeup;
        assign m_axis_twakeup = beat_out[WAKE_LSB];
    end else begin : g_no_twakeup
        assign m_axis_twakeup = 1'b0;
    end

    axis5_skid_buffer #(
        .DEPTH      (SKID_DEPTH),
        .DATA_WIDTH (BEAT_WIDTH)
    ) skid_inst (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr_valid (fub_axis_tvalid),
        .wr_ready (fub_axis_tready),
        .wr_data  (beat_in),
        .rd_valid (m_axis_tvalid),
        .rd_ready (m_axis_tready),
        .rd_data  (beat_out),
        .rd_count (buf_count)
    );

    // Parity travels in the low bits and is checked as the beat leaves
    if (ENABLE_PARITY) begin : g_tparity
        assign beat_in[0 +: STRB_WIDTH] = fub_axis_tparity;
        assign m_axis_tparity = beat_out[0 +: STRB_WIDTH];

        axis5_parity_checker #(
            .DATA_WIDTH (AXIS_DATA_WIDTH)
        ) parity_checker_inst (
            .aclk         (aclk),
            .aresetn      (aresetn),
            .beat_data    (m_axis_tdata),
            .beat_parity  (m_axis_tparity),
            .beat_valid   (m_axis_tvalid),
            .beat_ready   (m_axis_tready),
            .parity_error (parity_error)
        );
    end else begin : g_no_tparity
        assign m_axis_tparity = '0;
        assign parity_error = 1'b0;
    end

    // Stored beats or an offered beat
    assign busy = (buf_count != '0) || fub_axis_tvalid;

endmodule : axis5_master

// File: hw/axis5_parity_checker.sv
// axis5_parity_checker: per-byte parity check on outgoing beats with a sticky error flag

`timescale 1ns/1ps

module axis5_parity_checker #(
    parameter int DATA_WIDTH = 32,
    localparam int LANES = DATA_WIDTH / axis5_pkg::BYTE_WIDTH
) (
    input  logic                  aclk,
    input  logic                  aresetn,

    // Beat at the buffer head and its handshake
    input  logic [DATA_WIDTH-1:0] beat_data,
    input  logic [LANES-1:0]      beat_parity,
    input  logic                  beat_valid,
    input  logic                  beat_ready,

    output logic                  parity_error
);

    logic [LANES-1:0] expected_parity;
    logic             mismatch;

    // One XOR reduction per byte lane
    always_comb begin
        for (int lane = 0; lane < LANES; lane++) begin
            expected_parity[lane] =
                ^beat_data[lane * axis5_pkg::BYTE_WIDTH +: axis5_pkg::BYTE_WIDTH];
        end
    end

    // Only a beat that actually leaves is judged, so a stalled beat counts once
    assign mismatch = beat_valid && beat_ready && (expected_parity != beat_parity);

    // Sticky until reset
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            parity_error <= 1'b0;
        end else if (mismatch) begin
            parity_error <= 1'b1;
        end
    end

endmodule : axis5_parity_checker

// File: hw/axis5_skid_buffer.sv
// axis5_skid_buffer: register FIFO with valid/ready on both sides and an occupancy count

`timescale 1ns/1ps

module axis5_skid_buffer #(
    parameter int DEPTH = 4,
    parameter int DATA_WIDTH = 32,
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1),
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                   aclk,
    input  logic                   aresetn,

    // Write side
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  logic [DATA_WIDTH-1:0]  wr_data,

    // Read side, head entry shown combinationally
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic [COUNT_WIDTH-1:0] rd_count
);

    logic [DATA_WIDTH-1:0]  mem [DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   wr_en;
    logic                   rd_en;

    // Advance a pointer, wrapping at DEPTH so any depth works
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        logic [PTR_WIDTH-1:0] result;
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            result = '0;
        end else begin
            result = ptr + PTR_WIDTH'(1);
        end
        return result;
    endfunction

    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign rd_count = count;

    // A full buffer still accepts a beat when the head leaves in the same cycle
    assign wr_ready = (count < COUNT_WIDTH'(DEPTH)) || rd_en;

    assign wr_en = wr_valid && wr_ready;
    assign rd_en = rd_valid && rd_ready;

    // Storage
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
    end

    // Occupancy, unchanged on a simultaneous write and read
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10: count <= count + COUNT_WIDTH'(1);
                2'b01: count <= count - COUNT_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

endmodule : axis5_skid_buffer

// File: hw/axis5_pkg.sv
// axis5_pkg: default field widths and buffer depth for the AXI5-Stream master stage

package axis5_pkg;

    // Byte lane size, also the size of one parity group
    localparam int BYTE_WIDTH = 8;

    // tdata width, must be a multiple of BYTE_WIDTH
    localparam int DEFAULT_DATA_WIDTH = 32;

    // Sideband widths, zero means the field is absent
    localparam int DEFAULT_ID_WIDTH = 8;
    localparam int DEFAULT_DEST_WIDTH = 4;
    localparam int DEFAULT_USER_WIDTH = 1;

    // Entries in the output skid FIFO
    localparam int DEFAULT_SKID_DEPTH = 4;

endpackage : axis5_pkg
